/* common/mulDivPkg.sv */
// MIPS multiply/divide shared definitions
// Data widths, instruction field positions, opcodes and the operation type
package mulDivPkg;

    // --------------------
    // Data path widths
    // --------------------
    localparam int dataWidth = 32;

    // One engine iteration per result bit
    localparam int engineCycles = dataWidth;

    typedef logic [dataWidth-1:0]   wordT;
    typedef logic [2*dataWidth-1:0] doubleWordT;

    // --------------------
    // Instruction fields
    // --------------------
    // R-type field order is opcode | a | b | c | shamt | function
    localparam int fieldOpcodeLsb = 26;
    localparam int fieldALsb      = 21;
    localparam int fieldBLsb      = 16;
    localparam int fieldCLsb      = 11;
    localparam int fieldShamtLsb  = 6;

    // Register index width follows the width of the b field
    typedef logic [fieldALsb-fieldBLsb-1:0] regIndexT;

    // Major opcodes
    localparam logic [5:0] opcodeSpecial  = 6'h00;
    localparam logic [5:0] opcodeSpecial2 = 6'h1C;

    // SPECIAL function codes
    localparam logic [5:0] funcMult  = 6'h18;
    localparam logic [5:0] funcMultu = 6'h19;
    localparam logic [5:0] funcDiv   = 6'h1A;
    localparam logic [5:0] funcDivu  = 6'h1B;

    // SPECIAL2 function codes
    localparam logic [5:0] funcMadd  = 6'h00;
    localparam logic [5:0] funcMaddu = 6'h01;
    localparam logic [5:0] funcMul   = 6'h02;
    localparam logic [5:0] funcMsub  = 6'h04;
    localparam logic [5:0] funcMsubu = 6'h05;

    // Operation classes without signedness, which travels separately
    typedef enum logic [3:0] {
        opNone,
        opMult,
        opDiv,
        opMadd,
        opMsub,
        opMul
    } mulDivOpT;

endpackage

/* design/mipsMulDiv.sv */
// MIPS multiply/divide unit top level
// Decoder, handshake control and the two iterative engines
`timescale 1ns/10ps
module mipsMulDiv (
    input  logic                clock,
    input  logic                reset,
    input  logic                req,
    output logic                ack,
    input  mulDivPkg::wordT     instruction,
    input  mulDivPkg::wordT     operandA,
    input  mulDivPkg::wordT     operandB,
    output mulDivPkg::wordT     hi,
    output mulDivPkg::wordT     lo,
    output mulDivPkg::wordT     gprData,
    output mulDivPkg::regIndexT gprIndex,
    output logic                gprWrite,
    output logic                illegal
);

    // --------------------
    // Decode to control
    // --------------------
    mulDivPkg::mulDivOpT   op;
    logic                  isSigned;
    mulDivPkg::regIndexT   destIndex;
    logic                  decodeIllegal;

    // Control to engines and back
    logic                  mulStart;
    logic                  divStart;
    mulDivPkg::wordT       engineA;
    mulDivPkg::wordT       engineB;
    logic                  engineSigned;
    logic                  mulDone;
    logic                  divDone;
    mulDivPkg::doubleWordT mulResult;
    mulDivPkg::doubleWordT divResult;

    mulDivDecoder i_mulDivDecoder (
        .instruction (instruction),
        .op          (op),
        .isSigned    (isSigned),
        .destIndex   (destIndex),
        .illegal     (decodeIllegal)
    );

    mulDivControl i_mulDivControl (
        .clock         (clock),
        .reset         (reset),
        .req           (req),
        .ack           (ack),
        .op            (op),
        .isSigned      (isSigned),
        .destIndex     (destIndex),
        .decodeIllegal (decodeIllegal),
        .operandA      (operandA),
        .operandB      (operandB),
        .mulStart      (mulStart),
        .divStart      (divStart),
        .engineA       (engineA),
        .engineB       (engineB),
        .engineSigned  (engineSigned),
        .mulDone       (mulDone),
        .divDone       (divDone),
        .mulResult     (mulResult),
        .divResult     (divResult),
        .hi            (hi),
        .lo            (lo),
        .gprData       (gprData),
        .gprIndex      (gprIndex),
        .gprWrite      (gprWrite),
        .illegal       (illegal)
    );

    // Both engines share the operand bus and only one gets start
    shiftAddMultiplier i_shiftAddMultiplier (
        .clock    (clock),
        .reset    (reset),
        .start    (mulStart),
        .a        (engineA),
        .b        (engineB),
        .isSigned (engineSigned),
        .done     (mulDone),
        .product  (mulResult)
    );

    restoringDivider i_restoringDivider (
        .clock    (clock),
        .reset    (reset),
        .start    (divStart),
        .dividend (engineA),
        .divisor  (engineB),
        .isSigned (engineSigned),
        .done     (divDone),
        .result   (divResult)
    );

endmodule

/* design/mulDivControl.sv */
// Multiply/divide control
// Four-phase req/ack handshake, engine launch, HI/LO update and result hold
`timescale 1ns/10ps
module mulDivControl (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  mulDivPkg::mulDivOpT   op,
    input  logic                  isSigned,
    input  mulDivPkg::regIndexT   destIndex,
    input  logic                  decodeIllegal,
    input  mulDivPkg::wordT       operandA,
    input  mulDivPkg::wordT       operandB,
    output logic                  mulStart,
    output logic                  divStart,
    output mulDivPkg::wordT       engineA,
    output mulDivPkg::wordT       engineB,
    output logic                  engineSigned,
    input  logic                  mulDone,
    input  logic                  divDone,
    input  mulDivPkg::doubleWordT mulResult,
    input  mulDivPkg::doubleWordT divResult,
    output mulDivPkg::wordT       hi,
    output mulDivPkg::wordT       lo,
    output mulDivPkg::wordT       gprData,
    output mulDivPkg::regIndexT   gprIndex,
    output logic                  gprWrite,
    output logic                  illegal
);

    typedef enum logic [2:0] {
        stateIdle,
        stateRun,
        stateWrite,
        stateAckHigh,
        stateRelease
    } stateT;

    stateT                 state;
    mulDivPkg::mulDivOpT   opReg;
    mulDivPkg::doubleWordT hiLo;
    logic                  accept;

    // --------------------
    // Engine launch
    // --------------------
    // Start goes out in the accept cycle so the engine loads the live operands
    assign accept       = (state == stateIdle) && req;
    assign mulStart     = accept && !decodeIllegal && (op != mulDivPkg::opDiv);
    assign divStart     = accept && !decodeIllegal && (op == mulDivPkg::opDiv);
    assign engineA      = operandA;
    assign engineB      = operandB;
    assign engineSigned = isSigned;

    // Ack spans the hold and release states
    assign ack  = (state == stateAckHigh) || (state == stateRelease);
    assign hiLo = {hi, lo};

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= stateIdle;
            opReg    <= mulDivPkg::opNone;
            {hi, lo} <= '0;
            gprData  <= '0;
            gprIndex <= '0;
            gprWrite <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            case (state)
                stateIdle: if (req) begin
                    opReg    <= op;
                    gprIndex <= destIndex;
                    illegal  <= decodeIllegal;
                    gprWrite <= 1'b0;
                    state    <= stateRun;
                end
                // Illegal requests skip the engines entirely
                stateRun: if (illegal) begin
                    state <= stateWrite;
                end else if (mulDone || divDone) begin
                    case (opReg)
                        mulDivPkg::opMult: {hi, lo} <= mulResult;
                        mulDivPkg::opDiv:  {hi, lo} <= divResult;
                        mulDivPkg::opMadd: {hi, lo} <= hiLo + mulResult;
                        mulDivPkg::opMsub: {hi, lo} <= hiLo - mulResult;
                        mulDivPkg::opMul: begin
                            gprData  <= mulResult[mulDivPkg::dataWidth-1:0];
                            gprWrite <= 1'b1;
                        end
                        default: gprWrite <= 1'b0;
                    endcase
                    state <= stateWrite;
                end
                stateWrite: state <= stateAckHigh;
                // Outputs stay frozen while the requester holds req
                stateAckHigh: if (!req) state <= stateRelease;
                stateRelease: state <= stateIdle;
                default: state <= stateIdle;
            endcase
        end
    end

endmodule

/* design/mulDivDecoder.sv */
// MIPS multiply/divide instruction decoder
// Maps an instruction word to an operation class, signedness and destination
`timescale 1ns/10ps
module mulDivDecoder (
    input  mulDivPkg::wordT     instruction,
    output mulDivPkg::mulDivOpT op,
    output logic                isSigned,
    output mulDivPkg::regIndexT destIndex,
    output logic                illegal
);

    logic [5:0] opcode;
    logic [5:0] func;
    logic       shamtZero;
    logic       cZero;

    // Field extraction
    assign opcode    = instruction[mulDivPkg::fieldOpcodeLsb +: 6];
    assign func      = instruction[mulDivPkg::fieldShamtLsb-1:0];
    assign destIndex = instruction[mulDivPkg::fieldCLsb +: $bits(mulDivPkg::regIndexT)];
    assign shamtZero = (instruction[mulDivPkg::fieldCLsb-1:mulDivPkg::fieldShamtLsb] == '0);
    assign cZero     = (destIndex == '0);

    always_comb begin
        // Unmatched encodings fall through as illegal
        op      = mulDivPkg::opNone;
        illegal = 1'b1;
        if (opcode == mulDivPkg::opcodeSpecial && shamtZero && cZero) begin
            illegal = 1'b0;
            case (func)
                mulDivPkg::funcMult, mulDivPkg::funcMultu: op = mulDivPkg::opMult;
                mulDivPkg::funcDiv, mulDivPkg::funcDivu:   op = mulDivPkg::opDiv;
                default:                                   illegal = 1'b1;
            endcase
        end else if (opcode == mulDivPkg::opcodeSpecial2 && shamtZero) begin
            // Accumulate forms also need c zero since only MUL writes register c
            illegal = !cZero;
            case (func)
                mulDivPkg::funcMadd, mulDivPkg::funcMaddu: op = mulDivPkg::opMadd;
                mulDivPkg::funcMsub, mulDivPkg::funcMsubu: op = mulDivPkg::opMsub;
                mulDivPkg::funcMul: begin
                    op      = mulDivPkg::opMul;
                    illegal = 1'b0;
                end
                default: illegal = 1'b1;
            endcase
            if (illegal) begin
                op = mulDivPkg::opNone;
            end
        end
        // Even function codes are the signed forms
        isSigned = !illegal && !func[0];
    end

endmodule

/* divide/restoringDivider.sv */
// Iterative restoring divider
// Sign-magnitude, one quotient bit per cycle, remainder in the upper word
`timescale 1ns/10ps
module restoringDivider (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  mulDivPkg::wordT       dividend,
    input  mulDivPkg::wordT       divisor,
    input  logic                  isSigned,
    output logic                  done,
    output mulDivPkg::doubleWordT result
);

    logic                                       busy;
    logic [$clog2(mulDivPkg::engineCycles+1)-1:0] count;
    logic                                       lastStep;
    logic                                       negQuot;
    logic                                       negRem;
    mulDivPkg::wordT                            magDividend;
    mulDivPkg::wordT                            magDivisor;
    mulDivPkg::wordT                            divisorReg;
    mulDivPkg::wordT                            partial;
    mulDivPkg::wordT                            quotient;
    logic [mulDivPkg::dataWidth:0]              shifted;
    logic [mulDivPkg::dataWidth+1:0]            trial;

    assign magDividend = (isSigned && dividend[mulDivPkg::dataWidth-1]) ? -dividend : dividend;
    assign magDivisor  = (isSigned && divisor[mulDivPkg::dataWidth-1]) ? -divisor : divisor;
    assign lastStep    = (count == mulDivPkg::engineCycles);

    // Next dividend bit enters the partial remainder, then trial subtract
    assign shifted = {partial, quotient[mulDivPkg::dataWidth-1]};
    assign trial   = {1'b0, shifted} - {2'b00, divisorReg};

    // --------------------
    // Sequencing
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                busy  <= start;
                count <= '0;
            end else if (lastStep) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // --------------------
    // Datapath
    // --------------------
    // Quotient register starts with the dividend and fills with result bits
    always_ff @(posedge clock) begin
        if (!busy && start) begin
            partial    <= '0;
            quotient   <= magDividend;
            divisorReg <= magDivisor;
            negQuot    <= isSigned &&
                          (dividend[mulDivPkg::dataWidth-1] ^ divisor[mulDivPkg::dataWidth-1]);
            negRem     <= isSigned && dividend[mulDivPkg::dataWidth-1];
        end else if (busy && !lastStep) begin
            // Restore by keeping the shifted value when the trial goes negative
            partial  <= trial[mulDivPkg::dataWidth+1] ? shifted[mulDivPkg::dataWidth-1:0]
                                                       : trial[mulDivPkg::dataWidth-1:0];
            quotient <= {quotient[mulDivPkg::dataWidth-2:0], !trial[mulDivPkg::dataWidth+1]};
        end else if (busy) begin
            // Zero divisor never fails the trial, so quotient is all ones
            // and the remainder ends up as the dividend magnitude
            result <= {negRem ? -partial : partial, negQuot ? -quotient : quotient};
        end
    end

endmodule

/* files.f */
+incdir+tests
common/mulDivPkg.sv
design/mulDivDecoder.sv
design/mulDivControl.sv
multiply/shiftAddMultiplier.sv
divide/restoringDivider.sv
design/mipsMulDiv.sv
tests/mulDivTb.sv

/* multiply/shiftAddMultiplier.sv */
// Iterative shift-add multiplier
// Sign-magnitude, one multiplier bit per cycle, 64-bit product
`timescale 1ns/10ps
module shiftAddMultiplier (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  mulDivPkg::wordT       a,
    input  mulDivPkg::wordT       b,
    input  logic                  isSigned,
    output logic                  done,
    output mulDivPkg::doubleWordT product
);

    logic                                       busy;
    logic [$clog2(mulDivPkg::engineCycles+1)-1:0] count;
    logic                                       negate;
    logic                                       lastStep;
    mulDivPkg::wordT                            magA;
    mulDivPkg::wordT                            magB;
    mulDivPkg::wordT                            multiplier;
    mulDivPkg::doubleWordT                      multiplicand;
    mulDivPkg::doubleWordT                      accum;

    // Operand magnitudes where 0x80000000 stays as 2^31 unsigned
    assign magA     = (isSigned && a[mulDivPkg::dataWidth-1]) ? -a : a;
    assign magB     = (isSigned && b[mulDivPkg::dataWidth-1]) ? -b : b;
    assign lastStep = (count == mulDivPkg::engineCycles);

    // --------------------
    // Sequencing
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                busy  <= start;
                count <= '0;
            end else if (lastStep) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clock) begin
        if (!busy && start) begin
            multiplicand <= {{mulDivPkg::dataWidth{1'b0}}, magA};
            multiplier   <= magB;
            accum        <= '0;
            negate       <= isSigned && (a[mulDivPkg::dataWidth-1] ^ b[mulDivPkg::dataWidth-1]);
        end else if (busy && !lastStep) begin
            // Add shifted multiplicand for each set multiplier bit
            if (multiplier[0]) accum <= accum + multiplicand;
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end else if (busy) begin
            product <= negate ? -accum : accum;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the mipsMulDiv testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module mulDivTb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VmulDivTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

/* tests/mulDivVectors.svh */
// Multiply/divide test vectors
// Instruction encodings and the expected results, applied in table order
`ifndef MUL_DIV_VECTORS_SVH
`define MUL_DIV_VECTORS_SVH

// Every instruction reads registers a = 4 and b = 5
localparam logic [9:0] srcRegs  = 10'h085;
localparam logic [5:0] special  = mulDivPkg::opcodeSpecial;
localparam logic [5:0] special2 = mulDivPkg::opcodeSpecial2;

// Legal encodings with c and shamt zero unless named
localparam mulDivPkg::wordT insMult  = {special, srcRegs, 10'd0, mulDivPkg::funcMult};
localparam mulDivPkg::wordT insMultu = {special, srcRegs, 10'd0, mulDivPkg::funcMultu};
localparam mulDivPkg::wordT insDiv   = {special, srcRegs, 10'd0, mulDivPkg::funcDiv};
localparam mulDivPkg::wordT insDivu  = {special, srcRegs, 10'd0, mulDivPkg::funcDivu};
localparam mulDivPkg::wordT insMadd  = {special2, srcRegs, 10'd0, mulDivPkg::funcMadd};
localparam mulDivPkg::wordT insMaddu = {special2, srcRegs, 10'd0, mulDivPkg::funcMaddu};
localparam mulDivPkg::wordT insMsub  = {special2, srcRegs, 10'd0, mulDivPkg::funcMsub};
localparam mulDivPkg::wordT insMsubu = {special2, srcRegs, 10'd0, mulDivPkg::funcMsubu};
localparam mulDivPkg::wordT insMulC6 = {special2, srcRegs, 5'd6, 5'd0, mulDivPkg::funcMul};
localparam mulDivPkg::wordT insMulC31 = {special2, srcRegs, 5'd31, 5'd0, mulDivPkg::funcMul};

// Illegal encodings
localparam mulDivPkg::wordT insBadFunc   = {special, srcRegs, 10'd0, 6'h1F};
localparam mulDivPkg::wordT insMultShamt = {special, srcRegs, 5'd0, 5'd3, mulDivPkg::funcMult};
localparam mulDivPkg::wordT insBadFunc2  = {special2, srcRegs, 10'd0, 6'h3F};
localparam mulDivPkg::wordT insMaddC2    = {special2, srcRegs, 5'd2, 5'd0, mulDivPkg::funcMadd};

// Each row holds instruction, operandA and operandB
// then the expected {hi, lo}, gprData, gprIndex, gprWrite and illegal
task automatic loadVectors();
    // Signed and unsigned products of the same operands
    addVector(insMult, 'hFFFFFFFF, 'h00000002, 64'hFFFFFFFF_FFFFFFFE, 'h00000000, 0, 0, 0);
    addVector(insMultu, 'hFFFFFFFF, 'h00000002, 64'h00000001_FFFFFFFE, 'h00000000, 0, 0, 0);
    addVector(insMult, 'hFFFFFFFF, 'hFFFFFFFF, 64'h00000000_00000001, 'h00000000, 0, 0, 0);
    addVector(insMultu, 'hFFFFFFFF, 'hFFFFFFFF, 64'hFFFFFFFE_00000001, 'h00000000, 0, 0, 0);
    addVector(insMult, 'h12345678, 'hFFFFFF00, 64'hFFFFFFED_CBA98800, 'h00000000, 0, 0, 0);
    addVector(insMultu, 'h12345678, 'hFFFFFF00, 64'h12345665_CBA98800, 'h00000000, 0, 0, 0);
    // Remainder in HI, quotient in LO
    addVector(insDiv, 'hFFFFFF9C, 'h00000007, 64'hFFFFFFFE_FFFFFFF2, 'h00000000, 0, 0, 0);
    addVector(insDiv, 'h00000064, 'hFFFFFFF9, 64'h00000002_FFFFFFF2, 'h00000000, 0, 0, 0);
    addVector(insDivu, 'hFFFFFF9C, 'h00000007, 64'h00000002_24924916, 'h00000000, 0, 0, 0);
    addVector(insDiv, 'h00001234, 'h00000000, 64'h00001234_FFFFFFFF, 'h00000000, 0, 0, 0);
    addVector(insDiv, 'hFFFFFFF9, 'h00000000, 64'hFFFFFFF9_00000001, 'h00000000, 0, 0, 0);
    addVector(insDivu, 'h80000005, 'h00000000, 64'h80000005_FFFFFFFF, 'h00000000, 0, 0, 0);
    addVector(insDiv, 'h80000000, 'hFFFFFFFF, 64'h00000000_80000000, 'h00000000, 0, 0, 0);
    // Accumulate chain where each row builds on the one before
    addVector(insMult, 'h00010000, 'h00010000, 64'h00000001_00000000, 'h00000000, 0, 0, 0);
    addVector(insMadd, 'hFFFFFFFF, 'h00000001, 64'h00000000_FFFFFFFF, 'h00000000, 0, 0, 0);
    addVector(insMaddu, 'h00000001, 'h00000002, 64'h00000001_00000001, 'h00000000, 0, 0, 0);
    addVector(insMsubu, 'h00000003, 'h00000001, 64'h00000000_FFFFFFFE, 'h00000000, 0, 0, 0);
    addVector(insMsub, 'hFFFFFFFF, 'hFFFFFFFE, 64'h00000000_FFFFFFFC, 'h00000000, 0, 0, 0);
    addVector(insMsubu, 'hFFFFFFFF, 'hFFFFFFFF, 64'h00000002_FFFFFFFB, 'h00000000, 0, 0, 0);
    addVector(insMaddu, 'hFFFFFFFF, 'hFFFFFFFF, 64'h00000000_FFFFFFFC, 'h00000000, 0, 0, 0);
    // MUL leaves HI and LO alone
    addVector(insMulC6, 'hFFFFFFFD, 'h00000005, 64'h00000000_FFFFFFFC, 'hFFFFFFF1, 6, 1, 0);
    addVector(insMulC31, 'h00012345, 'h00010000, 64'h00000000_FFFFFFFC, 'h23450000, 31, 1, 0);
    addVector(insMultu, 'h00000003, 'h00000004, 64'h00000000_0000000C, 'h23450000, 0, 0, 0);
    // Illegal encodings keep every result register
    addVector(insBadFunc, 'h00000007, 'h00000009, 64'h00000000_0000000C, 'h23450000, 0, 0, 1);
    addVector(insMultShamt, 'hFFFFFFFF, 'h00000002, 64'h00000000_0000000C, 'h23450000, 0, 0, 1);
    addVector(insBadFunc2, 'h00000005, 'h00000006, 64'h00000000_0000000C, 'h23450000, 0, 0, 1);
    addVector(insMaddC2, 'h00000001, 'h00000001, 64'h00000000_0000000C, 'h23450000, 2, 0, 1);
    addVector(insDivu, 'h00000064, 'h0000000A, 64'h00000000_0000000A, 'h23450000, 0, 0, 0);
endtask

`endif

/* tests/mulDivTb.sv */
// Testbench for the MIPS multiply/divide unit
// Runs the vector table through the req/ack handshake and checks all outputs
`timescale 1ns/10ps
module mulDivTb;

    // Ack bound sits well above the 35 cycle legal latency
    localparam int ackTimeout     = mulDivPkg::engineCycles + 18;
    localparam int releaseTimeout = 5;
    localparam logic [15:0] lfsrSeed = 16'd48962;
    localparam logic [15:0] lfsrTaps = 16'hB400;

    logic                  clock;
    logic                  reset;
    logic                  req;
    logic                  ack;
    mulDivPkg::wordT       instruction;
    mulDivPkg::wordT       operandA;
    mulDivPkg::wordT       operandB;
    mulDivPkg::wordT       hi;
    mulDivPkg::wordT       lo;
    mulDivPkg::wordT       gprData;
    mulDivPkg::regIndexT   gprIndex;
    logic                  gprWrite;
    logic                  illegal;

    // Vector table columns
    mulDivPkg::wordT       vecInstr[$];
    mulDivPkg::wordT       vecA[$];
    mulDivPkg::wordT       vecB[$];
    mulDivPkg::doubleWordT vecHiLo[$];
    mulDivPkg::wordT       vecGprData[$];
    mulDivPkg::regIndexT   vecGprIndex[$];
    logic                  vecGprWrite[$];
    logic                  vecIllegal[$];

    int                    errorCount;
    int                    passCount;
    int                    failCount;
    logic                  timedOut;
    logic [15:0]           lfsrState;

    mipsMulDiv i_mipsMulDiv (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .ack         (ack),
        .instruction (instruction),
        .operandA    (operandA),
        .operandB    (operandB),
        .hi          (hi),
        .lo          (lo),
        .gprData     (gprData),
        .gprIndex    (gprIndex),
        .gprWrite    (gprWrite),
        .illegal     (illegal)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    `include "mulDivVectors.svh"

    // --------------------
    // Table and random helpers
    // --------------------
    task automatic addVector(input mulDivPkg::wordT instr, input mulDivPkg::wordT a,
                             input mulDivPkg::wordT b, input mulDivPkg::doubleWordT hiLo,
                             input mulDivPkg::wordT gpr, input int index, input int write,
                             input int bad);
        vecInstr.push_back(instr);
        vecA.push_back(a);
        vecB.push_back(b);
        vecHiLo.push_back(hiLo);
        vecGprData.push_back(gpr);
        vecGprIndex.push_back(mulDivPkg::regIndexT'(index));
        vecGprWrite.push_back(write != 0);
        vecIllegal.push_back(bad != 0);
    endtask

    // Galois form that shifts right and folds in the taps on a one
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) next = next ^ lfsrTaps;
        return next;
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int n = 0; n < count; n++) begin
            lfsrState = lfsrStep(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkWord(input string name, input mulDivPkg::wordT actual,
                             input mulDivPkg::wordT expected);
        if (actual !== expected) begin
            $display("[FAIL] %s got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkIndex(input string name, input mulDivPkg::regIndexT actual,
                              input mulDivPkg::regIndexT expected);
        if (actual !== expected) begin
            $display("[FAIL] %s got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] %s got 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    // All result outputs against one table row
    task automatic checkOutputs(input int idx);
        mulDivPkg::doubleWordT expHiLo;
        expHiLo = vecHiLo[idx];
        checkWord("hi", hi, expHiLo[2*mulDivPkg::dataWidth-1:mulDivPkg::dataWidth]);
        checkWord("lo", lo, expHiLo[mulDivPkg::dataWidth-1:0]);
        checkWord("gprData", gprData, vecGprData[idx]);
        checkIndex("gprIndex", gprIndex, vecGprIndex[idx]);
        checkFlag("gprWrite", gprWrite, vecGprWrite[idx]);
        checkFlag("illegal", illegal, vecIllegal[idx]);
    endtask

    task automatic reportTest(input string label, input int startErrors);
        if (errorCount == startErrors) begin
            passCount++;
            $display("%s passed", label);
        end else begin
            failCount++;
            $display("%s failed", label);
        end
    endtask

    // --------------------
    // Handshake driver
    // --------------------
    task automatic runVector(input int idx);
        int waitCount;
        int holdCycles;
        int startErrors;
        startErrors = errorCount;
        instruction = vecInstr[idx];
        operandA    = vecA[idx];
        operandB    = vecB[idx];
        req         = 1'b1;
        waitCount   = 0;
        while (!ack && waitCount < ackTimeout) begin
            @(posedge clock);
            #1;
            waitCount++;
        end
        if (!ack) begin
            $display("Timeout, vector %0d got no ack within %0d cycles", idx, ackTimeout);
            errorCount++;
            timedOut = 1'b1;
            req = 1'b0;
        end else begin
            checkOutputs(idx);
            // Results stay frozen under back-pressure
            drawBits(2, holdCycles);
            repeat (holdCycles) begin
                @(posedge clock);
                #1;
                checkFlag("ack", ack, 1'b1);
                checkOutputs(idx);
            end
            req = 1'b0;
            waitCount = 0;
            while (ack && waitCount < releaseTimeout) begin
                @(posedge clock);
                #1;
                waitCount++;
            end
            if (ack) begin
                $display("Timeout, vector %0d kept ack high after req dropped", idx);
                errorCount++;
                timedOut = 1'b1;
            end
        end
        reportTest($sformatf("vector %0d instruction 0x%h", idx, vecInstr[idx]), startErrors);
    endtask

    initial begin
        int idx;
        int startErrors;
        reset       = 1'b1;
        req         = 1'b0;
        instruction = '0;
        operandA    = '0;
        operandB    = '0;
        errorCount  = 0;
        passCount   = 0;
        failCount   = 0;
        timedOut    = 1'b0;
        lfsrState   = lfsrSeed;
        loadVectors();
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        // Idle state right after reset
        startErrors = errorCount;
        checkFlag("ack", ack, 1'b0);
        checkFlag("gprWrite", gprWrite, 1'b0);
        checkFlag("illegal", illegal, 1'b0);
        checkWord("hi", hi, '0);
        checkWord("lo", lo, '0);
        reportTest("reset state", startErrors);
        for (idx = 0; idx < vecInstr.size(); idx++) begin
            runVector(idx);
            if (timedOut) break;
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (errorCount == 0 && !timedOut) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
